// File: iomem_periph.f
+incdir+include
design/iomem_pkg.sv
design/periph_pkg.sv
design/iomem_decoder.sv
design/gpio_bank.sv
design/uart_core.sv
design/iomem_resp_merge.sv
design/iomem_periph_top.sv
test/iomem_checker.sv
test/tb_iomem_periph.sv

// File: Makefile
TOP = tb_iomem_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps -f iomem_periph.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: test/tb_iomem_periph.sv
// ##########################################################################
// Testbench top with clock, reset, bus master, UART loopback, timeout
// and final report.
// ##########################################################################

`timescale 1ns/10ps

`include "iomem_defs.svh"

module tb_iomem_periph;

	localparam int N_GPIO   = 16;  // Random GPIO writes.
	localparam int N_SW     = 8;   // Switch patterns.
	localparam int N_UART   = 2;   // Loopback bytes.
	localparam int DIV_MAX  = 13;  // Largest divider written.
	localparam int N_TRANS  = 4 + N_GPIO + 1 + N_SW + 2 + N_UART + 4;
	localparam int POLL_MAX = 2 * 10 * (DIV_MAX + 2) / 5;
	// Five edges per transaction, switch hold time, serial frames.
	localparam int LIMIT    = N_TRANS * 5 + N_SW * 4 + N_UART * 10 * (DIV_MAX + 2) + 200;

	localparam logic [31:0] A_GPIO_OUT  = {`IOMEM_GPIO_BASE, 14'b0, `REG_OFS_GPIO_OUT, 2'b0};
	localparam logic [31:0] A_GPIO_IN   = {`IOMEM_GPIO_BASE, 14'b0, `REG_OFS_GPIO_IN, 2'b0};
	localparam logic [31:0] A_UART_DIV  = {`IOMEM_UART_BASE, 14'b0, `REG_OFS_UART_DIV, 2'b0};
	localparam logic [31:0] A_UART_DATA = {`IOMEM_UART_BASE, 14'b0, `REG_OFS_UART_DATA, 2'b0};

	logic        clk;
	logic        resetn;
	logic        iomem_valid;
	logic [3:0]  iomem_wstrb;
	logic [31:0] iomem_addr;
	logic [31:0] iomem_wdata;
	logic        iomem_ready;
	logic [31:0] iomem_rdata;
	logic [3:0]  sw;
	logic [3:0]  leds;
	logic        ser_tx;
	logic [31:0] rd;
	logic [31:0] div_val;
	int          cycles;
	int          tests;
	int          fails;     // Failures found outside the checker.
	int          base_err;  // Error total at the end of the last test.

	iomem_periph_top dut (
		.clk         (clk),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_wstrb (iomem_wstrb),
		.iomem_addr  (iomem_addr),
		.iomem_wdata (iomem_wdata),
		.iomem_ready (iomem_ready),
		.iomem_rdata (iomem_rdata),
		.sw          (sw),
		.leds        (leds),
		.ser_tx      (ser_tx),
		.ser_rx      (ser_tx)  // Loopback.
	);

	iomem_checker chk (
		.clk         (clk),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_wstrb (iomem_wstrb),
		.iomem_addr  (iomem_addr),
		.iomem_wdata (iomem_wdata),
		.iomem_ready (iomem_ready),
		.iomem_rdata (iomem_rdata),
		.sw          (sw),
		.leds        (leds),
		.ser_tx      (ser_tx)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT) begin
				$display("Timeout: run not finished after %0d cycles", LIMIT);
				$display("Simulation FAILED");
				$finish;
			end
		end
	end

	// One transaction, held until ready, valid dropped on the ready edge.
	task automatic bus_xfer(input logic [31:0] addr, input logic [3:0] strb,
			input logic [31:0] data, output logic [31:0] rdata);
		@(posedge clk);
		iomem_valid <= 1'b1;
		iomem_addr  <= addr;
		iomem_wstrb <= strb;
		iomem_wdata <= data;
		do
			@(posedge clk);
		while (!iomem_ready);
		rdata = iomem_rdata;
		iomem_valid <= 1'b0;
	endtask

	// Read the UART buffer until the looped back byte shows up.
	task automatic poll_uart_byte();
		logic [31:0] data;
		int          n;
		n = 0;
		do begin
			bus_xfer(A_UART_DATA, 4'h0, 32'h0, data);
			n++;
		end while (data == 32'hffff_ffff && n < POLL_MAX);
		if (data == 32'hffff_ffff) begin
			fails++;
			$display("ERROR at %0t: no loopback byte after %0d reads", $time, n);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		@(negedge clk); // Checker has judged the last completion edge.
		errs = chk.errors + fails;
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errs - base_err);
		base_err = errs;
	endtask

	initial begin
		void'($urandom(40));
		tests       = 0;
		fails       = 0;
		base_err    = 0;
		resetn      = 1'b0;
		iomem_valid = 1'b0;
		iomem_wstrb = 4'h0;
		iomem_addr  = 32'h0;
		iomem_wdata = 32'h0;
		sw          = 4'h0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		bus_xfer(A_GPIO_OUT, 4'h0, 32'h0, rd);
		bus_xfer(A_UART_DIV, 4'h0, 32'h0, rd);
		bus_xfer(A_UART_DATA, 4'h0, 32'h0, rd); // Buffer empty.
		bus_xfer(A_GPIO_IN, 4'h0, 32'h0, rd);
		end_test("reset values");

		for (int i = 0; i < N_GPIO; i++)
			bus_xfer(A_GPIO_OUT, 4'($urandom_range(15, 1)), $urandom, rd);
		bus_xfer(A_GPIO_OUT, 4'h0, 32'h0, rd);
		end_test("gpio byte strobes");

		for (int i = 0; i < N_SW; i++) begin
			@(posedge clk);
			sw <= 4'($urandom);
			repeat (3) @(posedge clk); // Through the synchronizer.
			bus_xfer(A_GPIO_IN, 4'h0, 32'h0, rd);
		end
		end_test("switch input");

		div_val = 32'(6 + $urandom % 8);
		bus_xfer(A_UART_DIV, 4'hf, div_val, rd);
		bus_xfer(A_UART_DIV, 4'h0, 32'h0, rd);
		end_test("uart divider");

		bus_xfer(A_UART_DATA, 4'h1, $urandom, rd);
		bus_xfer(A_UART_DATA, 4'h1, $urandom, rd); // Held while the first frame runs.
		for (int i = 0; i < N_UART; i++)
			poll_uart_byte();
		end_test("uart loopback");

		bus_xfer({8'h40 | 8'($urandom % 16), 24'h0}, 4'hf, $urandom, rd);
		bus_xfer({8'h40 | 8'($urandom % 16), 24'h4}, 4'h0, 32'h0, rd);
		bus_xfer(A_GPIO_OUT, 4'h0, 32'h0, rd);
		bus_xfer(A_UART_DIV, 4'h0, 32'h0, rd);
		end_test("unmapped address");

		$display("Tests %0d, checks %0d, errors %0d", tests, chk.checks, chk.errors + fails);
		if (chk.errors + fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: test/iomem_checker.sv
// ##########################################################################
// Bus and serial line monitor with shadow GPIO and divider registers,
// reference read data, completion latency and start bit timing checks.
// ##########################################################################

`timescale 1ns/10ps

`include "iomem_defs.svh"

module iomem_checker (
	input logic        clk,
	input logic        resetn,
	input logic        iomem_valid,
	input logic [3:0]  iomem_wstrb,
	input logic [31:0] iomem_addr,
	input logic [31:0] iomem_wdata,
	input logic        iomem_ready,
	input logic [31:0] iomem_rdata,
	input logic [3:0]  sw,
	input logic [3:0]  leds,
	input logic        ser_tx
);

	int          errors;      // Failed checks.
	int          checks;      // Checks done.
	logic        in_flight;   // Transaction seen, not yet complete.
	int          lat;         // Edges since the capture edge.
	logic [31:0] t_addr;
	logic [31:0] t_wdata;
	logic [3:0]  t_wstrb;
	logic        t_stall;     // Issued while a frame was on the line.
	logic [31:0] gpio_sh;     // Shadow GPIO register.
	logic [31:0] div_sh;      // Shadow divider.
	logic [7:0]  tx_q[$];     // Bytes still to appear on the line.
	logic [7:0]  rx_q[$];     // Bytes still to be read back.
	logic        tx_prev;
	int          frame_left;  // Edges until the line may start a new frame.
	int          low_cnt;
	logic        measuring;   // Timing the low run after a start edge.
	logic [7:0]  frame_byte;

	// Byte lanes with a strobe take the new data.
	function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = wdata[8*i +: 8];
		end
		return res;
	endfunction

	// Read data before the write takes effect, UART data excluded.
	function automatic logic [31:0] expect_rdata(input logic [31:0] addr, input logic [31:0] gpio,
			input logic [31:0] div, input logic [3:0] swv);
		if (addr[31:24] == `IOMEM_GPIO_BASE && addr[9:2] == `REG_OFS_GPIO_OUT)
			return gpio;
		if (addr[31:24] == `IOMEM_GPIO_BASE && addr[9:2] == `REG_OFS_GPIO_IN)
			return {28'b0, swv};
		if (addr[31:24] == `IOMEM_UART_BASE && addr[9:2] == `REG_OFS_UART_DIV)
			return div;
		return 32'b0; // Unmapped region or offset.
	endfunction

	// Zero bits that follow the start bit, LSB first.
	function automatic int trailing_zeros(input logic [7:0] b);
		int n;
		n = 0;
		while (n < 8 && !b[n])
			n++;
		return n;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_completion();
		logic is_data;
		is_data = t_addr[31:24] == `IOMEM_UART_BASE && t_addr[9:2] == `REG_OFS_UART_DATA;
		if (is_data && |t_wstrb) begin
			if (t_stall ? lat <= 3 : lat != 3)
				report_error($sformatf("UART write done after %0d cycles, stall %0b", lat, t_stall));
		end else begin
			if (lat != 3)
				report_error($sformatf("transaction done after %0d cycles, not 3", lat));
			if (is_data && rx_q.size() == 0)
				compare_value("iomem_rdata", 32'hffff_ffff, iomem_rdata); // Empty buffer.
			else if (is_data && iomem_rdata != 32'hffff_ffff)
				compare_value("iomem_rdata", {24'b0, rx_q.pop_front()}, iomem_rdata);
			else if (!is_data) begin
				compare_value("iomem_rdata", expect_rdata(t_addr, gpio_sh, div_sh, sw), iomem_rdata);
				if (t_addr[31:24] == `IOMEM_GPIO_BASE && t_addr[9:2] == `REG_OFS_GPIO_OUT)
					gpio_sh = merge_lanes(gpio_sh, t_wdata, t_wstrb);
				if (t_addr[31:24] == `IOMEM_UART_BASE && t_addr[9:2] == `REG_OFS_UART_DIV)
					div_sh = merge_lanes(div_sh, t_wdata, t_wstrb);
			end
		end
		compare_value("leds", {28'b0, gpio_sh[3:0]}, {28'b0, leds});
	endtask

	always @(posedge clk) begin
		if (!resetn) begin
			in_flight  = 1'b0;
			gpio_sh    = 32'b0;
			div_sh     = `IOMEM_UART_DIV_RESET;
			tx_q.delete();
			rx_q.delete();
			tx_prev    = 1'b1;
			frame_left = 0;
			measuring  = 1'b0;
		end else begin
			if (in_flight) begin
				lat++;
				if (iomem_ready) begin
					in_flight = 1'b0;
					check_completion();
				end
			end else if (iomem_valid) begin
				in_flight = 1'b1; // Capture edge of a new transaction.
				lat       = 0;
				t_addr    = iomem_addr;
				t_wdata   = iomem_wdata;
				t_wstrb   = iomem_wstrb;
				t_stall   = frame_left > 0;
				if (iomem_addr[31:24] == `IOMEM_UART_BASE && iomem_addr[9:2] == `REG_OFS_UART_DATA
						&& |iomem_wstrb) begin
					tx_q.push_back(iomem_wdata[7:0]);
					rx_q.push_back(iomem_wdata[7:0]);
				end
			end
			if (measuring) begin
				if (!ser_tx)
					low_cnt++;
				else begin
					measuring = 1'b0; // Start bit plus leading zero data bits.
					compare_value("start bit length", div_sh * (1 + trailing_zeros(frame_byte)),
						low_cnt);
				end
			end
			if (frame_left > 0)
				frame_left--;
			else if (tx_prev && !ser_tx) begin
				if (tx_q.size() == 0)
					report_error("serial frame started with no byte written");
				else begin
					frame_byte = tx_q.pop_front();
					measuring  = 1'b1;
					low_cnt    = 1;
					frame_left = 10 * div_sh; // Start, 8 data and stop bits.
				end
			end
			tx_prev = ser_tx;
		end
	end

endmodule

// File: design/iomem_periph_top.sv
// ##########################################################################
// Peripheral subsystem top with decoder, GPIO, UART and response merge.
// ##########################################################################

`timescale 1ns/10ps

module iomem_periph_top (
	input  logic        clk,
	input  logic        resetn,
	input  logic        iomem_valid,
	input  logic [3:0]  iomem_wstrb,
	input  logic [31:0] iomem_addr,
	input  logic [31:0] iomem_wdata,
	output logic        iomem_ready,
	output logic [31:0] iomem_rdata,
	input  logic [3:0]  sw,
	output logic [3:0]  leds,
	output logic        ser_tx,
	input  logic        ser_rx
);

	iomem_pkg::iomem_req_t req;      // Registered request to all blocks.
	iomem_pkg::iomem_rsp_t gpio_rsp;
	iomem_pkg::iomem_rsp_t uart_rsp;
	logic                  done;     // Transaction complete.

	iomem_decoder u_decoder (
		.clk         (clk),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_wstrb (iomem_wstrb),
		.iomem_addr  (iomem_addr),
		.iomem_wdata (iomem_wdata),
		.done        (done),
		.req         (req)
	);

	gpio_bank u_gpio (
		.clk    (clk),
		.resetn (resetn),
		.req    (req),
		.sw     (sw),
		.leds   (leds),
		.rsp    (gpio_rsp)
	);

	uart_core u_uart (
		.clk    (clk),
		.resetn (resetn),
		.req    (req),
		.ser_rx (ser_rx),
		.ser_tx (ser_tx),
		.rsp    (uart_rsp)
	);

	iomem_resp_merge u_merge (
		.clk         (clk),
		.resetn      (resetn),
		.req         (req),
		.gpio_rsp    (gpio_rsp),
		.uart_rsp    (uart_rsp),
		.iomem_ready (iomem_ready),
		.iomem_rdata (iomem_rdata),
		.done        (done)
	);

endmodule

// File: design/iomem_resp_merge.sv
// ##########################################################################
// Response merge, unmapped answer, bus ready and rdata.
// ##########################################################################

`timescale 1ns/10ps

module iomem_resp_merge (
	input  logic                   clk,
	input  logic                   resetn,
	input  iomem_pkg::iomem_req_t  req,
	input  iomem_pkg::iomem_rsp_t  gpio_rsp,
	input  iomem_pkg::iomem_rsp_t  uart_rsp,
	output logic                   iomem_ready,
	output logic [31:0]            iomem_rdata,
	output logic                   done         // Frees the decoder.
);

	logic none_hit;   // Unmapped request, aligned with peripheral responses.
	logic any_ready;

	assign any_ready = gpio_rsp.ready | uart_rsp.ready | none_hit;
	assign done      = iomem_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			none_hit    <= 1'b0;
			iomem_ready <= 1'b0;
		end else begin
			none_hit    <= req.valid && (req.region == iomem_pkg::REGION_NONE);
			iomem_ready <= any_ready; // One-cycle pulse.
		end
	end

	// Idle responses carry zero data, so a plain OR merges them.
	always_ff @(posedge clk) begin
		iomem_rdata <= gpio_rsp.rdata | uart_rsp.rdata;
	end

endmodule

// File: design/uart_core.sv
// ##########################################################################
// UART with divider register, 8N1 transmitter with write stall, and
// receiver with a one-byte buffer.
// ##########################################################################

`timescale 1ns/10ps

`include "iomem_defs.svh"

module uart_core (
	input  logic                   clk,
	input  logic                   resetn,
	input  iomem_pkg::iomem_req_t  req,
	input  logic                   ser_rx,
	output logic                   ser_tx,
	output iomem_pkg::iomem_rsp_t  rsp
);

	logic [31:0]                 div;          // Cycles per bit.
	logic                        acc;          // Request for this block.
	logic                        sel_ok;
	periph_pkg::periph_reg_e     sel;
	logic                        data_wr;      // New byte from the bus.
	logic                        data_rd;      // Buffer read, clears valid.
	logic                        tx_pend;      // Write held by a busy transmitter.
	logic [7:0]                  tx_pend_data;
	logic                        tx_launch;    // Start a frame this cycle.
	logic [7:0]                  tx_byte;
	periph_pkg::uart_tx_state_e  tx_state;
	logic [31:0]                 tx_cnt;
	logic [2:0]                  tx_bit;
	logic [7:0]                  tx_shift;
	logic                        tx_tick;
	logic [1:0]                  rx_sync;      // Input synchronizer.
	periph_pkg::uart_rx_state_e  rx_state;
	logic [31:0]                 rx_cnt;
	logic [2:0]                  rx_bit;
	logic [7:0]                  rx_shift;
	logic [7:0]                  rx_data;      // Receive buffer.
	logic                        rx_valid;
	logic                        rx_tick;      // Full bit time.
	logic                        rx_half;      // Middle of the start bit.

	assign acc     = req.valid && (req.region == iomem_pkg::REGION_UART);
	assign data_wr = acc && sel_ok && sel == periph_pkg::REG_UART_DATA && |req.wstrb;
	assign data_rd = acc && sel_ok && sel == periph_pkg::REG_UART_DATA && !(|req.wstrb);

	assign tx_byte   = tx_pend ? tx_pend_data : req.wdata[7:0];
	assign tx_launch = (data_wr || tx_pend) && tx_state == periph_pkg::TX_IDLE;
	assign tx_tick   = (tx_cnt + 32'd1 >= div);
	assign rx_tick   = (rx_cnt + 32'd1 >= div);
	assign rx_half   = (rx_cnt + 32'd1 >= {1'b0, div[31:1]});

	always_comb begin
		sel    = periph_pkg::REG_UART_DIV;
		sel_ok = 1'b1;
		case (req.offset)
			`REG_OFS_UART_DIV:  sel = periph_pkg::REG_UART_DIV;
			`REG_OFS_UART_DATA: sel = periph_pkg::REG_UART_DATA;
			default:            sel_ok = 1'b0;
		endcase
	end

	// Bus side: divider, response and the held data write.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			div     <= `IOMEM_UART_DIV_RESET;
			rsp     <= '0;
			tx_pend <= 1'b0;
		end else begin
			rsp <= '0;
			if (acc && !data_wr) begin
				rsp.ready <= 1'b1;
				if (sel_ok && sel == periph_pkg::REG_UART_DIV) begin
					rsp.rdata <= div; // Old value.
					for (int i = 0; i < 4; i++) begin
						if (req.wstrb[i])
							div[8*i +: 8] <= req.wdata[8*i +: 8];
					end
				end else if (data_rd) begin
					rsp.rdata <= rx_valid ? {24'b0, rx_data} : 32'hffff_ffff;
				end
			end
			if (data_wr && !tx_launch) begin
				tx_pend      <= 1'b1; // Stall until the line is free.
				tx_pend_data <= req.wdata[7:0];
			end
			if (tx_launch) begin
				tx_pend   <= 1'b0;
				rsp.ready <= 1'b1; // Ack once the frame starts.
			end
		end
	end

	// Transmitter, LSB first, line idles high.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_state <= periph_pkg::TX_IDLE;
			ser_tx   <= 1'b1;
			tx_cnt   <= 32'b0;
			tx_bit   <= 3'b0;
		end else begin
			tx_cnt <= tx_tick ? 32'b0 : tx_cnt + 32'd1;
			case (tx_state)
				periph_pkg::TX_IDLE: begin
					tx_cnt <= 32'b0;
					if (tx_launch) begin
						tx_shift <= tx_byte;
						ser_tx   <= 1'b0; // Start bit.
						tx_state <= periph_pkg::TX_START;
					end
				end
				periph_pkg::TX_START: begin
					if (tx_tick) begin
						ser_tx   <= tx_shift[0];
						tx_bit   <= 3'b0;
						tx_state <= periph_pkg::TX_DATA;
					end
				end
				periph_pkg::TX_DATA: begin
					if (tx_tick) begin
						if (tx_bit == 3'd7) begin
							ser_tx   <= 1'b1; // Stop bit.
							tx_state <= periph_pkg::TX_STOP;
						end else begin
							ser_tx   <= tx_shift[1];
							tx_shift <= tx_shift >> 1;
							tx_bit   <= tx_bit + 3'd1;
						end
					end
				end
				default: begin
					if (tx_tick)
						tx_state <= periph_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// Receiver, samples each bit at its middle.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_sync  <= 2'b11;
			rx_state <= periph_pkg::RX_IDLE;
			rx_cnt   <= 32'b0;
			rx_bit   <= 3'b0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], ser_rx};
			rx_cnt  <= rx_cnt + 32'd1;
			if (data_rd)
				rx_valid <= 1'b0; // A new byte below wins.
			case (rx_state)
				periph_pkg::RX_IDLE: begin
					rx_cnt <= 32'b0;
					if (!rx_sync[1])
						rx_state <= periph_pkg::RX_START;
				end
				periph_pkg::RX_START: begin
					if (rx_half) begin
						rx_cnt   <= 32'b0;
						rx_bit   <= 3'b0;
						rx_state <= rx_sync[1] ? periph_pkg::RX_IDLE : periph_pkg::RX_DATA;
					end
				end
				periph_pkg::RX_DATA: begin
					if (rx_tick) begin
						rx_cnt   <= 32'b0;
						rx_shift <= {rx_sync[1], rx_shift[7:1]};
						rx_bit   <= rx_bit + 3'd1;
						if (rx_bit == 3'd7)
							rx_state <= periph_pkg::RX_STOP;
					end
				end
				default: begin
					if (rx_tick) begin
						rx_state <= periph_pkg::RX_IDLE;
						if (rx_sync[1]) begin // Framing ok.
							rx_data  <= rx_shift;
							rx_valid <= 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: design/gpio_bank.sv
// ##########################################################################
// GPIO output register with byte strobes and synchronized switch input.
// ##########################################################################

`timescale 1ns/10ps

`include "iomem_defs.svh"

module gpio_bank (
	input  logic                   clk,
	input  logic                   resetn,
	input  iomem_pkg::iomem_req_t  req,
	input  logic [3:0]             sw,
	output logic [3:0]             leds,
	output iomem_pkg::iomem_rsp_t  rsp
);

	logic [31:0]              gpio;     // Output register.
	logic [3:0]               sw_meta;  // First synchronizer stage.
	logic [3:0]               sw_sync;  // Second stage, safe to read.
	logic                     acc;      // Request for this block.
	logic                     sel_ok;   // Offset maps to a register.
	periph_pkg::periph_reg_e  sel;

	assign acc  = req.valid && (req.region == iomem_pkg::REGION_GPIO);
	assign leds = gpio[3:0];

	always_comb begin
		sel    = periph_pkg::REG_GPIO_OUT;
		sel_ok = 1'b1;
		case (req.offset)
			`REG_OFS_GPIO_OUT: sel = periph_pkg::REG_GPIO_OUT;
			`REG_OFS_GPIO_IN:  sel = periph_pkg::REG_GPIO_IN;
			default:           sel_ok = 1'b0; // Acked with zero data.
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			sw_meta <= 4'b0;
			sw_sync <= 4'b0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			gpio <= 32'b0;
			rsp  <= '0;
		end else begin
			rsp <= '0;
			if (acc) begin
				rsp.ready <= 1'b1;
				if (sel_ok && sel == periph_pkg::REG_GPIO_OUT) begin
					rsp.rdata <= gpio; // Old value, also on a write.
					for (int i = 0; i < 4; i++) begin
						if (req.wstrb[i])
							gpio[8*i +: 8] <= req.wdata[8*i +: 8];
					end
				end else if (sel_ok && sel == periph_pkg::REG_GPIO_IN) begin
					rsp.rdata <= {28'b0, sw_sync}; // Writes ignored.
				end
			end
		end
	end

endmodule

// File: design/iomem_decoder.sv
// ##########################################################################
// Bus request capture and region decode.
// ##########################################################################

`timescale 1ns/10ps

`include "iomem_defs.svh"

module iomem_decoder (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   iomem_valid,
	input  logic [3:0]             iomem_wstrb,
	input  logic [31:0]            iomem_addr,
	input  logic [31:0]            iomem_wdata,
	input  logic                   done,        // Completion from the merger.
	output iomem_pkg::iomem_req_t  req
);

	logic               busy;     // Transaction in flight.
	logic               take;     // Capture this cycle.
	iomem_pkg::region_e region;   // Decoded region of the live address.

	assign take = iomem_valid && !busy;

	// Upper address byte picks the peripheral.
	always_comb begin
		case (iomem_addr[31:24])
			`IOMEM_GPIO_BASE: region = iomem_pkg::REGION_GPIO;
			`IOMEM_UART_BASE: region = iomem_pkg::REGION_UART;
			default:          region = iomem_pkg::REGION_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy      <= 1'b0;
			req.valid <= 1'b0;
		end else begin
			req.valid <= 1'b0; // One-cycle pulse.
			if (done) begin
				busy <= 1'b0; // Master drops valid next cycle.
			end else if (take) begin
				busy       <= 1'b1;
				req.valid  <= 1'b1;
				req.wstrb  <= iomem_wstrb;
				req.offset <= iomem_addr[9:2]; // Word offset.
				req.wdata  <= iomem_wdata;
				req.region <= region;
			end
		end
	end

endmodule

// File: design/periph_pkg.sv
// ##########################################################################
// Peripheral register select and UART FSM state encodings.
// ##########################################################################

package periph_pkg;

	// Register inside a region.
	typedef enum logic [1:0] {
		REG_GPIO_OUT  = 2'd0,
		REG_GPIO_IN   = 2'd1,
		REG_UART_DIV  = 2'd2,
		REG_UART_DATA = 2'd3
	} periph_reg_e;

	// Transmitter FSM.
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} uart_tx_state_e;

	// Receiver FSM.
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} uart_rx_state_e;

endpackage

// File: design/iomem_pkg.sv
// ##########################################################################
// Bus request and response structs, region select enum.
// ##########################################################################

package iomem_pkg;

	// Peripheral region picked from address bits 31..24.
	typedef enum logic [1:0] {
		REGION_NONE = 2'd0, // Unmapped, answered by the merger.
		REGION_GPIO = 2'd1,
		REGION_UART = 2'd2
	} region_e;

	// Registered request, valid for one cycle per transaction.
	typedef struct packed {
		logic        valid;  // Single-cycle strobe.
		logic [3:0]  wstrb;  // Byte lanes, zero means read.
		logic [7:0]  offset; // Address bits 9..2.
		logic [31:0] wdata;
		region_e     region;
	} iomem_req_t;

	// Peripheral response, rdata is zero while ready is low.
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} iomem_rsp_t;

endpackage

// File: include/iomem_defs.svh
// ##########################################################################
// Address map, register offsets and UART divider reset value for the
// iomem peripheral subsystem.
// ##########################################################################

`ifndef IOMEM_DEFS_SVH
`define IOMEM_DEFS_SVH

// Upper address byte that selects a peripheral region.
`define IOMEM_GPIO_BASE 8'h03
`define IOMEM_UART_BASE 8'h02

// Word offsets inside the GPIO region.
`define REG_OFS_GPIO_OUT 8'h00
`define REG_OFS_GPIO_IN  8'h01

// Word offsets inside the UART region.
`define REG_OFS_UART_DIV  8'h00
`define REG_OFS_UART_DATA 8'h01

// Clock cycles per serial bit after reset.
`define IOMEM_UART_DIV_RESET 32'd16

`endif
